// ==== verification/mp_clk_cases.txt ====
# mbist scan scan_en exp_mode dratio tratio d0 d1 t0 t1 axim | d0 d1 t0 t1 apb
# exp_mode 0 func, 1 mbist, 2 scan; last five are rising edges per 60-cycle window
0 0 0 0 0 0 0 0 0 0 0   0  0  0  0 30
0 0 0 0 0 0 1 0 0 0 1  60  0  0  0 30
0 0 0 0 0 0 0 1 0 0 0   0 60  0  0 30
0 0 0 0 0 0 0 0 1 0 1   0  0 60  0 30
0 0 0 0 0 0 0 0 0 1 0   0  0  0 60 30
0 0 0 0 0 0 1 1 1 1 1  60 60 60 60 30
1 0 0 1 0 1 0 0 0 0 0  60 60 30 30 30
1 0 0 1 1 0 1 1 1 1 1  30 30 60 60 30
1 0 0 1 3 7 0 1 0 1 0  15 15  7  7 30
1 0 0 1 7 3 1 0 1 0 1   7  7 15 15 30
1 0 0 1 1 3 0 0 0 0 0  30 30 15 15 30
0 1 0 2 3 1 0 0 0 0 1  15 15 30 30 30
1 1 0 2 0 7 1 1 1 1 0  60 60  7  7 30
0 1 1 2 3 7 0 0 0 0 1  60 60 60 60 60
1 1 1 2 1 1 0 0 0 0 0  60 60 60 60 60
0 0 1 0 5 5 0 0 0 0 1  60 60 60 60 60
0 0 0 0 0 0 1 0 1 0 0  60  0 60  0 30

// ==== project.f ====
source/clk_ctrl_pkg.sv
source/icg_cell.sv
source/ram_bist_clk_div.sv
source/bus_clk_en_gen.sv
source/mp_clk_top.sv
verification/tb_clk_gen.sv
verification/mp_clk_top_assert.sv
verification/tb_mp_clk_top.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_mp_clk_top

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): project.f $(wildcard source/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert -f project.f --top-module tb_mp_clk_top -Mdir obj_dir

run: compile
	@./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q '\*\* FAIL \*\*' sim.log; then \
	  echo "Simulation failed"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

// ==== verification/tb_mp_clk_top.sv ====
// Run from the project root; case file holds 16 integer columns per line, '#' lines are skipped
module tb_mp_clk_top;

  import clk_ctrl_pkg::*;

  localparam int ratio_w       = RATIO_W_DEF;
  localparam int clk_period    = 20;
  localparam int rst_cycles    = 4;
  localparam int drive_dly     = 2;
  localparam int settle_cycles = 8;
  localparam int window_cycles = 60;
  localparam int case_budget   = 80;

  logic bist_clk, rst_b, jtg_tclk;
  logic mbist_mode, scan_mode, icg_scan_en;
  logic [ratio_w-1:0] data_ratio, tag_ratio;
  logic data_en_0, data_en_1, tag_en_0, tag_en_1, axim_en;
  logic cpuclk, core0_clk, core1_clk, jtgclk, apb_clk, apb_clk_en, axim_clk_en_f;
  logic data_clk_0, data_clk_1, tag_clk_0, tag_clk_1;

  // Free-running edge counters, one per observed clock
  int n_cpu, n_core0, n_core1, n_d0, n_d1, n_t0, n_t1, n_apb, n_jtg_src, n_jtg_out;
  int cnt_start [10];
  string clk_name [10] = '{"forever_cpuclk", "forever_core0_clk", "forever_core1_clk",
    "l2c_data_clk_bank_0", "l2c_data_clk_bank_1", "l2c_tag_clk_bank_0",
    "l2c_tag_clk_bank_1", "apb_clk", "pad_had_jtg_tclk", "forever_jtgclk"};

  // Case lines and the fields of the current one
  string case_q [$];
  int    fld [16];
  int    n_cases, err_count, err_level, err_mode;
  bit    file_ok, cases_loaded;

  tb_clk_gen #(.period (clk_period), .rst_cycles (rst_cycles)) u_clk_gen
  (
    .clk   (bist_clk),
    .rst_b (rst_b)
  );

  // JTAG test clock, slower and unrelated to the root clock
  initial
  begin
    jtg_tclk = 1'b0;
    forever #33 jtg_tclk = ~jtg_tclk;
  end

  mp_clk_top #(.ratio_w (ratio_w)) i_mp_clk_top
  (
    .bist_clk (bist_clk), .pad_yy_dft_clk_rst_b (rst_b), .phl_rst_b (rst_b),
    .pad_had_jtg_tclk (jtg_tclk), .pad_yy_mbist_mode (mbist_mode),
    .pad_yy_scan_mode (scan_mode), .pad_yy_icg_scan_en (icg_scan_en),
    .pad_l2c_data_mbist_clk_ratio (data_ratio), .pad_l2c_tag_mbist_clk_ratio (tag_ratio),
    .l2c_data_ram_clk_en_bank_0 (data_en_0), .l2c_data_ram_clk_en_bank_1 (data_en_1),
    .l2c_tag_ram_clk_en_bank_0 (tag_en_0), .l2c_tag_ram_clk_en_bank_1 (tag_en_1),
    .axim_clk_en (axim_en), .forever_cpuclk (cpuclk), .forever_core0_clk (core0_clk),
    .forever_core1_clk (core1_clk), .forever_jtgclk (jtgclk), .apb_clk (apb_clk),
    .apb_clk_en (apb_clk_en), .axim_clk_en_f (axim_clk_en_f),
    .l2c_data_clk_bank_0 (data_clk_0), .l2c_data_clk_bank_1 (data_clk_1),
    .l2c_tag_clk_bank_0 (tag_clk_0), .l2c_tag_clk_bank_1 (tag_clk_1)
  );

  // ========================================
  // Edge counting
  // ========================================

  always @(posedge cpuclk) n_cpu <= n_cpu + 1;
  always @(posedge core0_clk) n_core0 <= n_core0 + 1;
  always @(posedge core1_clk) n_core1 <= n_core1 + 1;
  always @(posedge data_clk_0) n_d0 <= n_d0 + 1;
  always @(posedge data_clk_1) n_d1 <= n_d1 + 1;
  always @(posedge tag_clk_0) n_t0 <= n_t0 + 1;
  always @(posedge tag_clk_1) n_t1 <= n_t1 + 1;
  always @(posedge apb_clk) n_apb <= n_apb + 1;
  always @(posedge jtg_tclk) n_jtg_src <= n_jtg_src + 1;
  always @(posedge jtgclk) n_jtg_out <= n_jtg_out + 1;

  function automatic int edges_of(input int idx);
    case (idx)
      0: return n_cpu;
      1: return n_core0;
      2: return n_core1;
      3: return n_d0;
      4: return n_d1;
      5: return n_t0;
      6: return n_t1;
      7: return n_apb;
      8: return n_jtg_src;
      default: return n_jtg_out;
    endcase
  endfunction

  // Mode rule from the pads: scan first, then MBIST
  function automatic clk_mode_e decode_pads(input logic mb, input logic sc);
    if (sc)
      return MODE_SCAN;
    else if (mb)
      return MODE_MBIST;
    return MODE_FUNC;
  endfunction

  // ========================================
  // Compare tasks
  // ========================================

  task automatic check_count(input string what, input int got, input int exp, input int tol);
    if ((got < exp - tol) || (got > exp + tol))
    begin
      err_count++;
      $display("[ERROR] %0t %s: %0d edges, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      err_level++;
      $display("[ERROR] %0t %s: level %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_mode(input string what, input clk_mode_e got, input clk_mode_e exp);
    if (got !== exp)
    begin
      err_mode++;
      $display("[ERROR] %0t %s %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic parse_line(input string line, output int n);
    n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
      fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
      fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15]);
  endtask

  // ========================================
  // One case: drive, settle, count
  // ========================================

  task automatic run_case(input int idx);
    int n;
    int i;
    int en_high;
    clk_mode_e exp_mode;
    logic axim_old;
    logic axim_new;
    parse_line(case_q[idx], n);
    exp_mode = clk_mode_e'(fld[3][1:0]);
    axim_old = axim_en;
    axim_new = fld[10][0];
    // New levels just after a rising edge
    @(posedge bist_clk);
    #(drive_dly);
    mbist_mode  = fld[0][0];
    scan_mode   = fld[1][0];
    icg_scan_en = fld[2][0];
    data_ratio  = fld[4][ratio_w-1:0];
    tag_ratio   = fld[5][ratio_w-1:0];
    data_en_0   = fld[6][0];
    data_en_1   = fld[7][0];
    tag_en_0    = fld[8][0];
    tag_en_1    = fld[9][0];
    axim_en     = axim_new;
    check_mode("mode from pads", decode_pads(mbist_mode, scan_mode), exp_mode);
    // AXI enable moves at the next root edge, not before
    @(negedge bist_clk);
    // Decoded mode inside the DUT, settled by now
    check_mode("mode in the DUT", i_mp_clk_top.clk_mode, exp_mode);
    check_level("axim_clk_en_f before the next edge", axim_clk_en_f, axim_old);
    @(negedge bist_clk);
    check_level("axim_clk_en_f one cycle later", axim_clk_en_f, axim_new);
    repeat (settle_cycles - 2) @(negedge bist_clk);
    for (i = 0; i < 10; i++)
      cnt_start[i] = edges_of(i);
    en_high = 0;
    // Window of whole root cycles, negedge to negedge
    repeat (window_cycles)
    begin
      @(negedge bist_clk);
      if (exp_mode == MODE_SCAN)
        check_level("apb_clk_en in scan mode", apb_clk_en, 1'b1);
      if (apb_clk_en === 1'b1)
        en_high++;
      check_level("axim_clk_en_f stable", axim_clk_en_f, axim_new);
    end
    // Half-rate APB enable outside scan mode
    if (exp_mode != MODE_SCAN)
      check_count("apb_clk_en high cycles", en_high, window_cycles / 2, 0);
    for (i = 0; i < 8; i++)
    begin
      if (i < 3)
        check_count(clk_name[i], edges_of(i) - cnt_start[i], window_cycles, 0);
      else
        check_count(clk_name[i], edges_of(i) - cnt_start[i], fld[i + 8], 1);
    end
    check_count(clk_name[9], edges_of(9) - cnt_start[9], edges_of(8) - cnt_start[8], 0);
  endtask

  // ========================================
  // Main sequence
  // ========================================

  initial
  begin
    int fd;
    int n;
    string line;
    mbist_mode  = 1'b0;
    scan_mode   = 1'b0;
    icg_scan_en = 1'b0;
    data_ratio  = '0;
    tag_ratio   = '0;
    data_en_0   = 1'b0;
    data_en_1   = 1'b0;
    tag_en_0    = 1'b0;
    tag_en_1    = 1'b0;
    axim_en     = 1'b0;
    fd = $fopen("verification/mp_clk_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Case file verification/mp_clk_cases.txt could not be opened");
    end
    else
    begin
      file_ok = 1'b1;
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        parse_line(line, n);
        if (n == 16)
          case_q.push_back(line);
      end
      $fclose(fd);
    end
    n_cases = case_q.size();
    cases_loaded = 1'b1;
    if (file_ok && (n_cases == 0))
      $display("The case file holds no cases");
    wait (rst_b === 1'b1);
    for (int c = 0; c < n_cases; c++)
      run_case(c);
    $display("Errors: %0d count, %0d level, %0d mode", err_count, err_level, err_mode);
    if ((err_count + err_level + err_mode == 0) && file_ok && (n_cases > 0))
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // Watchdog sized from the case count
  initial
  begin
    int limit;
    wait (cases_loaded);
    limit = (n_cases * case_budget + rst_cycles) * clk_period;
    #(limit);
    $display("Timeout: the cases did not finish within %0d time units", limit);
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== verification/mp_clk_top_assert.sv ====
// Bound into every RAM divider; keeps a shadow of the ratio the counter last loaded
module mp_clk_top_assert
#(
  parameter int ratio_w = clk_ctrl_pkg::RATIO_W_DEF
)
(
  input logic                    bist_clk,
  input logic                    pad_yy_dft_clk_rst_b,
  input logic                    cnt_clk,
  input clk_ctrl_pkg::clk_mode_e clk_mode,
  input logic [ratio_w-1:0]      ratio,
  input logic [ratio_w-1:0]      ratio_cnt,
  input logic                    gate_en_0,
  input logic                    gate_en_1
);

  import clk_ctrl_pkg::*;

  // Ratio taken at the last reload
  logic [ratio_w-1:0] loaded_ratio;
  // MBIST or scan
  logic               in_test;

  assign in_test = (clk_mode == MODE_MBIST) || (clk_mode == MODE_SCAN);

  // Same reload condition as the counter itself
  always_ff @(posedge cnt_clk or negedge pad_yy_dft_clk_rst_b)
  begin
    if (!pad_yy_dft_clk_rst_b)
    begin
      loaded_ratio <= '0;
    end
    else if (in_test && (ratio_cnt == '0))
    begin
      loaded_ratio <= ratio;
    end
  end

  // ========================================
  // Counter checks
  // ========================================

  cnt_within_ratio: assert property (@(posedge bist_clk) disable iff (!pad_yy_dft_clk_rst_b)
    ratio_cnt <= loaded_ratio)
    else $error("ratio counter above the loaded ratio");

  // Previous cycle functional, so no count at the edge between
  cnt_held_func: assert property (@(posedge bist_clk) disable iff (!pad_yy_dft_clk_rst_b)
    ($past(clk_mode) == MODE_FUNC) |-> $stable(ratio_cnt))
    else $error("ratio counter moved in functional mode");

  // ========================================
  // Bank enable check
  // ========================================

  bank_en_equal: assert property (@(posedge bist_clk) disable iff (!pad_yy_dft_clk_rst_b)
    (clk_mode != MODE_FUNC) |-> (gate_en_0 == gate_en_1))
    else $error("bank enables differ in a test mode");

endmodule

bind ram_bist_clk_div mp_clk_top_assert
#(
  .ratio_w (ratio_w)
)
u_div_assert
(
  .bist_clk             (bist_clk),
  .pad_yy_dft_clk_rst_b (pad_yy_dft_clk_rst_b),
  .cnt_clk              (cnt_clk),
  .clk_mode             (clk_mode),
  .ratio                (ratio),
  .ratio_cnt            (ratio_cnt),
  .gate_en_0            (gate_en_0),
  .gate_en_1            (gate_en_1)
);

// ==== verification/tb_clk_gen.sv ====
// Clock runs from time zero; reset releases 2 units after the last held rising edge
module tb_clk_gen
#(
  parameter int period     = 20,
  parameter int rst_cycles = 4
)
(
  output logic clk,
  output logic rst_b
);

  // Square wave, first rise at period/2
  initial
  begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // Reset held over rst_cycles rising edges
  initial
  begin
    rst_b = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    #2 rst_b = 1'b1;
  end

endmodule

// ==== source/mp_clk_top.sv ====
// One root clock for all outputs; scan beats MBIST in mode decode; no PLL, OCC or clock buffers
module mp_clk_top
#(
  parameter int ratio_w = clk_ctrl_pkg::RATIO_W_DEF
)
(
  input  logic               bist_clk,
  input  logic               pad_yy_dft_clk_rst_b,
  input  logic               phl_rst_b,
  input  logic               pad_had_jtg_tclk,
  input  logic               pad_yy_mbist_mode,
  input  logic               pad_yy_scan_mode,
  input  logic               pad_yy_icg_scan_en,
  input  logic [ratio_w-1:0] pad_l2c_data_mbist_clk_ratio,
  input  logic [ratio_w-1:0] pad_l2c_tag_mbist_clk_ratio,
  input  logic               l2c_data_ram_clk_en_bank_0,
  input  logic               l2c_data_ram_clk_en_bank_1,
  input  logic               l2c_tag_ram_clk_en_bank_0,
  input  logic               l2c_tag_ram_clk_en_bank_1,
  input  logic               axim_clk_en,
  output logic               forever_cpuclk,
  output logic               forever_core0_clk,
  output logic               forever_core1_clk,
  output logic               forever_jtgclk,
  output logic               apb_clk,
  output logic               apb_clk_en,
  output logic               axim_clk_en_f,
  output logic               l2c_data_clk_bank_0,
  output logic               l2c_data_clk_bank_1,
  output logic               l2c_tag_clk_bank_0,
  output logic               l2c_tag_clk_bank_1
);

  import clk_ctrl_pkg::*;

  // Decoded operating mode, the only mode seen below
  clk_mode_e clk_mode;

  // ========================================
  // Mode decode
  // ========================================

  // Scan first, then MBIST
  // Anything else is functional
  always_comb
  begin
    if (pad_yy_scan_mode)
    begin
      clk_mode = MODE_SCAN;
    end
    else if (pad_yy_mbist_mode)
    begin
      clk_mode = MODE_MBIST;
    end
    else
    begin
      clk_mode = MODE_FUNC;
    end
  end

  // ========================================
  // CPU and core clocks
  // ========================================

  // Ungated, zero latency
  assign forever_cpuclk    = bist_clk;
  assign forever_core0_clk = bist_clk;
  assign forever_core1_clk = bist_clk;

  // ========================================
  // JTAG clock
  // ========================================

  // Test clock straight from the pad
  assign forever_jtgclk = pad_had_jtg_tclk;

  // ========================================
  // APB and AXI enables
  // ========================================

  bus_clk_en_gen u_bus_en
  (
    .bist_clk      (bist_clk),
    .phl_rst_b     (phl_rst_b),
    .scan_en       (pad_yy_icg_scan_en),
    .clk_mode      (clk_mode),
    .axim_clk_en   (axim_clk_en),
    .apb_clk       (apb_clk),
    .apb_clk_en    (apb_clk_en),
    .axim_clk_en_f (axim_clk_en_f)
  );

  // ========================================
  // L2 data RAM clocks
  // ========================================

  // Two data banks, own ratio
  ram_bist_clk_div
  #(
    .ratio_w (ratio_w)
  )
  u_data_div
  (
    .bist_clk             (bist_clk),
    .pad_yy_dft_clk_rst_b (pad_yy_dft_clk_rst_b),
    .scan_en              (pad_yy_icg_scan_en),
    .clk_mode             (clk_mode),
    .ratio                (pad_l2c_data_mbist_clk_ratio),
    .bank_en_0            (l2c_data_ram_clk_en_bank_0),
    .bank_en_1            (l2c_data_ram_clk_en_bank_1),
    .bank_clk_0           (l2c_data_clk_bank_0),
    .bank_clk_1           (l2c_data_clk_bank_1)
  );

  // ========================================
  // L2 tag RAM clocks
  // ========================================

  // Two tag banks, separate counter
  ram_bist_clk_div
  #(
    .ratio_w (ratio_w)
  )
  u_tag_div
  (
    .bist_clk             (bist_clk),
    .pad_yy_dft_clk_rst_b (pad_yy_dft_clk_rst_b),
    .scan_en              (pad_yy_icg_scan_en),
    .clk_mode             (clk_mode),
    .ratio                (pad_l2c_tag_mbist_clk_ratio),
    .bank_en_0            (l2c_tag_ram_clk_en_bank_0),
    .bank_en_1            (l2c_tag_ram_clk_en_bank_1),
    .bank_clk_0           (l2c_tag_clk_bank_0),
    .bank_clk_1           (l2c_tag_clk_bank_1)
  );

endmodule

// ==== source/bus_clk_en_gen.sv ====
// APB runs at half the root rate from reset release; AXI enable is a plain one-cycle delay
module bus_clk_en_gen
(
  input  logic                    bist_clk,
  input  logic                    phl_rst_b,
  input  logic                    scan_en,
  input  clk_ctrl_pkg::clk_mode_e clk_mode,
  input  logic                    axim_clk_en,
  output logic                    apb_clk,
  output logic                    apb_clk_en,
  output logic                    axim_clk_en_f
);

  import clk_ctrl_pkg::*;

  // Peripheral toggle, flips every root cycle
  logic peri_tgl;
  // Toggle copy one cycle later, drives the APB gate
  logic apb_clk_en_f;

  // ========================================
  // APB enable
  // ========================================

  always_ff @(posedge bist_clk or negedge phl_rst_b)
  begin
    if (!phl_rst_b)
    begin
      peri_tgl     <= 1'b0;
      apb_clk_en_f <= 1'b0;
    end
    else
    begin
      peri_tgl     <= ~peri_tgl;
      // High every other cycle
      apb_clk_en_f <= peri_tgl;
    end
  end

  // Scan mode exports a constant enable
  assign apb_clk_en = (clk_mode == MODE_SCAN) ? 1'b1 : apb_clk_en_f;

  // ========================================
  // APB clock
  // ========================================

  // One pulse per two root cycles
  icg_cell u_apb_icg
  (
    .clk_in  (bist_clk),
    .en      (apb_clk_en_f),
    .scan_en (scan_en),
    .clk_out (apb_clk)
  );

  // ========================================
  // AXI master enable
  // ========================================

  always_ff @(posedge bist_clk or negedge phl_rst_b)
  begin
    if (!phl_rst_b)
    begin
      axim_clk_en_f <= 1'b0;
    end
    else
    begin
      axim_clk_en_f <= axim_clk_en;
    end
  end

endmodule

// ==== source/ram_bist_clk_div.sv ====
// One RAM type (two banks); the ratio is sampled only when the counter reaches zero
module ram_bist_clk_div
#(
  parameter int ratio_w = clk_ctrl_pkg::RATIO_W_DEF
)
(
  input  logic                   bist_clk,
  input  logic                   pad_yy_dft_clk_rst_b,
  input  logic                   scan_en,
  input  clk_ctrl_pkg::clk_mode_e clk_mode,
  input  logic [ratio_w-1:0]     ratio,
  input  logic                   bank_en_0,
  input  logic                   bank_en_1,
  output logic                   bank_clk_0,
  output logic                   bank_clk_1
);

  import clk_ctrl_pkg::*;

  localparam logic [ratio_w-1:0] cnt_one = 1;

  // MBIST or scan mode active
  logic               test_en;
  // Gated clock for the ratio counter
  logic               cnt_clk;
  // Ratio down-counter
  logic [ratio_w-1:0] ratio_cnt;
  // Counter at zero, one RAM pulse due
  logic               cnt_idle;
  // Final per-bank gate enables
  logic               gate_en_0;
  logic               gate_en_1;

  assign test_en = is_test_mode(clk_mode);

  // ========================================
  // Counter clock
  // ========================================

  // Runs only in test modes
  // Scan shift may also open it
  icg_cell u_cnt_icg
  (
    .clk_in  (bist_clk),
    .en      (test_en),
    .scan_en (scan_en),
    .clk_out (cnt_clk)
  );

  // ========================================
  // Ratio counter
  // ========================================

  // Reload from the pad ratio at zero, else count down
  // Holds in functional mode even when scan shift clocks it
  always_ff @(posedge cnt_clk or negedge pad_yy_dft_clk_rst_b)
  begin
    if (!pad_yy_dft_clk_rst_b)
    begin
      ratio_cnt <= '0;
    end
    else if (test_en)
    begin
      if (cnt_idle)
      begin
        ratio_cnt <= ratio;
      end
      else
      begin
        ratio_cnt <= ratio_cnt - cnt_one;
      end
    end
  end

  assign cnt_idle = (ratio_cnt == '0);

  // ========================================
  // Bank enable select
  // ========================================

  // Test modes: both banks on the idle flag
  // Functional: cache enables per bank
  assign gate_en_0 = test_en ? cnt_idle : bank_en_0;
  assign gate_en_1 = test_en ? cnt_idle : bank_en_1;

  // ========================================
  // Bank clock gates
  // ========================================

  // Bank 0
  icg_cell u_bank0_icg
  (
    .clk_in  (bist_clk),
    .en      (gate_en_0),
    .scan_en (scan_en),
    .clk_out (bank_clk_0)
  );

  // Bank 1
  icg_cell u_bank1_icg
  (
    .clk_in  (bist_clk),
    .en      (gate_en_1),
    .scan_en (scan_en),
    .clk_out (bank_clk_1)
  );

endmodule

// ==== source/icg_cell.sv ====
// Behavioural latch-based clock gate for simulation; swap for the library ICG cell in synthesis
module icg_cell
(
  input  logic clk_in,
  input  logic en,
  input  logic scan_en,
  output logic clk_out
);

  // ========================================
  // Enable latch
  // ========================================

  // Combined enable seen by the latch
  logic en_comb;
  // Latched enable, stable while clk_in is high
  logic en_lat;

  // Scan shift forces the gate open
  assign en_comb = en | scan_en;

  // Transparent in the low phase only
  // Enable changes after a rising edge take effect at the next pulse
  always_latch
  begin
    if (!clk_in)
    begin
      en_lat = en_comb;
    end
  end

  // ========================================
  // Gating
  // ========================================

  // AND with the high phase, so no partial pulse
  assign clk_out = clk_in & en_lat;

endmodule

// ==== source/clk_ctrl_pkg.sv ====
// Shared clock-mode encoding and ratio width; mode values are fixed 2-bit codes, 3 is unused
package clk_ctrl_pkg;

  // ========================================
  // Clock mode
  // ========================================

  // Operating mode of the clock block
  // Decoded once at the top from the pad levels
  typedef enum logic [1:0]
  {
    MODE_FUNC  = 2'd0,
    MODE_MBIST = 2'd1,
    MODE_SCAN  = 2'd2
  } clk_mode_e;

  // ========================================
  // MBIST ratio
  // ========================================

  // Default width of the pad ratio fields
  // Ratio r gives one RAM clock pulse per r+1 root cycles
  parameter int RATIO_W_DEF = 3;

  // True in any test mode (MBIST or scan)
  // Test modes share the divided RAM clocking
  function automatic logic is_test_mode(input clk_mode_e mode);
    logic test;
    test = (mode == MODE_MBIST) || (mode == MODE_SCAN);
    return test;
  endfunction

endpackage
